/* Bender.yml */
package:
  name: uart

sources:
  - uart_pkg.sv
  - uart_baud_gen.sv
  - uart_tx.sv
  - uart_rx.sv
  - uart_cfg_regs.sv
  - uart_top.sv
  - target: simulation
    files:
      - tb_uart_top.sv

/* tb_uart_top.sv */
`timescale 1ns/100ps

/*
 * Testbench for the UART subsystem
 * Loopback and bit-banged frames, start while busy, divisor change and
 * framing errors, checked against a queue of sent words
 */
module tb_uart_top
    import uart_pkg::*;
();

    localparam int       NB_DATA    = 8;
    localparam divisor_t RST_DIV    = 16'd3;
    localparam int       WAIT_LIMIT = 5000;  // Cycles, well over one frame at divisor 7
    localparam time      DRIVE_DLY  = 1;

    logic               clk;
    logic               i_rst;
    logic               i_cfg_we;
    divisor_t           i_cfg_divisor;
    logic               i_tx_start;
    logic [NB_DATA-1:0] i_tx_data;
    logic               i_rx;
    logic               o_tx;
    logic               o_tx_done;
    logic               o_rx_valid;
    logic [NB_DATA-1:0] o_rx_data;
    logic               o_frame_err_sticky;

    logic               bang_sel;    // Line from the bit-banger instead of o_tx
    logic               bang_line;
    logic               expect_err;
    divisor_t           cur_div;
    logic [NB_DATA-1:0] exp_q[$];    // Words sent, oldest first
    int                 done_count  = 0;
    int                 rx_count    = 0;
    int                 start_count = 0;

    assign i_rx = bang_sel ? bang_line : o_tx;

    uart_top #(
        .NB_DATA       (NB_DATA),
        .RESET_DIVISOR (RST_DIV)
    ) uart_top_i (
        .clk                (clk),
        .i_rst              (i_rst),
        .i_cfg_we           (i_cfg_we),
        .i_cfg_divisor      (i_cfg_divisor),
        .i_tx_start         (i_tx_start),
        .i_tx_data          (i_tx_data),
        .i_rx               (i_rx),
        .o_tx               (o_tx),
        .o_tx_done          (o_tx_done),
        .o_rx_valid         (o_rx_valid),
        .o_rx_data          (o_rx_data),
        .o_frame_err_sticky (o_frame_err_sticky)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    task automatic report_mismatch(input string name, input logic [31:0] exp_val,
                                   input logic [31:0] act_val);
        $display("ERROR at %0t: %s expected 0x%0h, got 0x%0h", $time, name, exp_val, act_val);
        $display("SIMULATION FAILED");
        $fatal(1);
    endtask

    task automatic abort_run(input string why);
        $display("Run stopped at %0t: %s", $time, why);
        $display("SIMULATION FAILED");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [31:0] exp_val,
                               input logic [31:0] act_val);
        assert (act_val === exp_val)
            else report_mismatch(name, exp_val, act_val);
    endtask

    // Counters sampled at posedge, waits look at them on negedge
    always @(posedge clk) begin
        if (!i_rst && o_tx_done)
            done_count = done_count + 1;
    end

    always @(posedge clk) begin : rx_monitor
        logic [NB_DATA-1:0] exp_word;
        if (!i_rst && o_rx_valid) begin
            if (exp_q.size() == 0) begin
                abort_run("o_rx_valid pulsed with no word outstanding");
            end else begin
                exp_word = exp_q.pop_front();
                check_value("o_rx_data", exp_word, o_rx_data);
                rx_count = rx_count + 1;
            end
        end
    end

    a_no_frame_err: assert property (@(posedge clk) disable iff (i_rst)
        !expect_err |-> !o_frame_err_sticky)
        else report_mismatch("o_frame_err_sticky", 0, 1);

    a_done_single: assert property (@(posedge clk) disable iff (i_rst)
        o_tx_done |=> !o_tx_done)
        else report_mismatch("o_tx_done", 0, 1);

    a_valid_single: assert property (@(posedge clk) disable iff (i_rst)
        o_rx_valid |=> !o_rx_valid)
        else report_mismatch("o_rx_valid", 0, 1);

    task automatic wait_tx_done(input int target);
        int n;
        n = 0;
        while (done_count < target && n < WAIT_LIMIT) begin
            @(negedge clk);
            n++;
        end
        if (done_count < target)
            abort_run("o_tx_done did not pulse for the frame in flight");
    endtask

    task automatic wait_rx_drained();
        int n;
        n = 0;
        while (exp_q.size() != 0 && n < WAIT_LIMIT) begin
            @(negedge clk);
            n++;
        end
        if (exp_q.size() != 0)
            abort_run("a sent word never came back on o_rx_valid");
    endtask

    task automatic wait_sticky(input logic level);
        int n;
        n = 0;
        while (o_frame_err_sticky !== level && n < WAIT_LIMIT) begin
            @(negedge clk);
            n++;
        end
        if (o_frame_err_sticky !== level)
            abort_run("o_frame_err_sticky never reached the expected level");
    endtask

    task automatic send_word(input logic [NB_DATA-1:0] data);
        @(posedge clk);
        #DRIVE_DLY;
        i_tx_data  = data;
        i_tx_start = 1'b1;
        exp_q.push_back(data);
        start_count = start_count + 1;
        @(posedge clk);
        #DRIVE_DLY;
        i_tx_start = 1'b0;
    endtask

    task automatic loop_word(input logic [NB_DATA-1:0] data);
        send_word(data);
        wait_tx_done(start_count);
        wait_rx_drained();
    endtask

    task automatic write_divisor(input divisor_t div);
        @(posedge clk);
        #DRIVE_DLY;
        i_cfg_we      = 1'b1;
        i_cfg_divisor = div;
        @(posedge clk);
        #DRIVE_DLY;
        i_cfg_we = 1'b0;
        cur_div  = div;
    endtask

    // Cycles of the first low stretch on o_tx
    task automatic measure_start_low(output int cycles);
        int n;
        cycles = 0;
        n      = 0;
        while (o_tx !== 1'b0 && n < WAIT_LIMIT) begin
            @(negedge clk);
            n++;
        end
        while (o_tx === 1'b0 && cycles < WAIT_LIMIT) begin
            @(negedge clk);
            cycles++;
        end
        if (cycles == 0 || cycles >= WAIT_LIMIT)
            abort_run("no start bit seen on o_tx");
    endtask

    task automatic hold_line(input logic level, input int cycles);
        bang_line = level;
        repeat (cycles) @(posedge clk);
        #DRIVE_DLY;
    endtask

    task automatic bang_frame(input logic [NB_DATA-1:0] data, input logic stop_bit);
        int bit_cycles;
        bit_cycles = OVERSAMPLE * (int'(cur_div) + 1);
        @(posedge clk);
        #DRIVE_DLY;
        bang_sel = 1'b1;                     // Both sources idle high here
        hold_line(1'b0, bit_cycles);
        for (int i = 0; i < NB_DATA; i++)
            hold_line(data[i], bit_cycles);  // LSB first
        hold_line(stop_bit, bit_cycles);
        hold_line(1'b1, bit_cycles);
        bang_sel = 1'b0;
    endtask

    initial begin : stimulus
        int                 low_cycles;
        int                 bit_cycles;
        logic [NB_DATA-1:0] word;
        void'($urandom(32'he529e205));
        i_rst         = 1'b1;
        i_cfg_we      = 1'b0;
        i_cfg_divisor = RST_DIV;
        i_tx_start    = 1'b0;
        i_tx_data     = '0;
        bang_sel      = 1'b1;
        bang_line     = 1'b1;
        expect_err    = 1'b0;
        cur_div       = RST_DIV;
        repeat (4) @(posedge clk);
        #DRIVE_DLY;
        i_rst = 1'b0;

        @(negedge clk);
        check_value("o_tx", 1, o_tx);
        check_value("o_tx_done", 0, o_tx_done);
        check_value("o_rx_valid", 0, o_rx_valid);
        check_value("o_frame_err_sticky", 0, o_frame_err_sticky);
        @(posedge clk);
        #DRIVE_DLY;
        bang_sel = 1'b0;  // Loopback from here on

        repeat (20) begin
            word = NB_DATA'($urandom);
            loop_word(word);
        end

        // Second strobe lands mid frame and must be dropped
        send_word(8'ha5);
        repeat (200) @(posedge clk);
        #DRIVE_DLY;
        i_tx_data  = 8'h3c;
        i_tx_start = 1'b1;
        @(posedge clk);
        #DRIVE_DLY;
        i_tx_start = 1'b0;
        wait_tx_done(start_count);
        wait_rx_drained();
        repeat (10 * OVERSAMPLE * (int'(cur_div) + 1) + 100) @(negedge clk);
        check_value("o_tx_done count", start_count, done_count);
        check_value("o_rx_valid count", start_count, rx_count);

        write_divisor(16'd7);
        loop_word(NB_DATA'($urandom));
        word = NB_DATA'($urandom) | NB_DATA'(1);  // LSB high ends the start bit cleanly
        send_word(word);
        measure_start_low(low_cycles);
        bit_cycles = OVERSAMPLE * (int'(cur_div) + 1);
        // First tick can fall anywhere inside one tick period
        assert (low_cycles >= bit_cycles - int'(cur_div) - 1 && low_cycles <= bit_cycles + 2)
            else report_mismatch("start bit low cycles", bit_cycles, low_cycles);
        wait_tx_done(start_count);
        wait_rx_drained();
        repeat (5) loop_word(NB_DATA'($urandom));

        expect_err = 1'b1;
        word       = NB_DATA'($urandom);
        exp_q.push_back(word);
        bang_frame(word, 1'b0);
        wait_rx_drained();
        wait_sticky(1'b1);
        write_divisor(16'd7);  // Any write clears the flag
        wait_sticky(1'b0);
        expect_err = 1'b0;
        loop_word(NB_DATA'($urandom));

        $display("SIMULATION PASSED");
        $finish;
    end

endmodule

/* uart.f */
uart_pkg.sv
uart_baud_gen.sv
uart_tx.sv
uart_rx.sv
uart_cfg_regs.sv
uart_top.sv
tb_uart_top.sv

/* uart_baud_gen.sv */
`timescale 1ns/100ps

/*
 * Baud tick generator
 * Pulses o_tick for one cycle every i_divisor + 1 clk cycles
 */
module uart_baud_gen
    import uart_pkg::*;
(
    input  logic     clk,
    input  logic     i_rst,
    input  divisor_t i_divisor,
    output logic     o_tick
);

    divisor_t cnt_q;
    divisor_t div_q;   // Divisor seen on the previous cycle
    logic     tick_q;

    always_ff @(posedge clk) begin
        if (i_rst) begin
            cnt_q  <= '0;
            div_q  <= '0;
            tick_q <= 1'b0;
        end else begin
            div_q <= i_divisor;
            if (i_divisor != div_q) begin
                // New rate, restart the period
                cnt_q  <= i_divisor;
                tick_q <= 1'b0;
            end else if (cnt_q == '0) begin
                cnt_q  <= i_divisor;
                tick_q <= 1'b1;
            end else begin
                cnt_q  <= cnt_q - 1'b1;
                tick_q <= 1'b0;
            end
        end
    end

    assign o_tick = tick_q;

    a_tick_single: assert property (@(posedge clk) disable iff (i_rst)
        (o_tick && i_divisor != '0) |=> !o_tick);

endmodule

/* uart_cfg_regs.sv */
`timescale 1ns/100ps

/*
 * UART configuration and status
 * Baud divisor register and sticky framing-error flag
 */
module uart_cfg_regs
    import uart_pkg::*;
#(
    parameter divisor_t RESET_DIVISOR = 16'd26
) (
    input  logic     clk,
    input  logic     i_rst,
    input  logic     i_cfg_we,
    input  divisor_t i_cfg_divisor,
    input  logic     i_frame_err,
    output divisor_t o_divisor,
    output logic     o_frame_err_sticky
);

    divisor_t divisor_q;
    logic     sticky_q;

    always_ff @(posedge clk) begin
        if (i_rst) begin
            divisor_q <= RESET_DIVISOR;
        end else if (i_cfg_we) begin
            divisor_q <= i_cfg_divisor;
        end
    end

    // A new error beats a clearing write in the same cycle
    always_ff @(posedge clk) begin
        if (i_rst) begin
            sticky_q <= 1'b0;
        end else if (i_frame_err) begin
            sticky_q <= 1'b1;
        end else if (i_cfg_we) begin
            sticky_q <= 1'b0;
        end
    end

    assign o_divisor          = divisor_q;
    assign o_frame_err_sticky = sticky_q;

endmodule

/* uart_pkg.sv */
/*
 * UART shared definitions
 * Divisor and tick-count types, oversampling constants and the
 * state encodings of the transmit and receive machines
 */
package uart_pkg;

    // Tick period is divisor + 1 clk cycles
    typedef logic [15:0] divisor_t;

    typedef logic [3:0] tick_cnt_t;  // Position inside one bit period

    localparam int        OVERSAMPLE = 16;    // Ticks per bit
    localparam tick_cnt_t MID_TICK   = 4'd7;  // Receiver sample point

    // Transmit FSM, one-hot
    typedef enum logic [3:0] {
        TX_IDLE  = 4'b0001,
        TX_START = 4'b0010,
        TX_DATA  = 4'b0100,
        TX_STOP  = 4'b1000
    } tx_state_t;

    // Receive FSM, one-hot
    typedef enum logic [3:0] {
        RX_IDLE  = 4'b0001,
        RX_START = 4'b0010,
        RX_DATA  = 4'b0100,
        RX_STOP  = 4'b1000
    } rx_state_t;

endpackage

/* uart_rx.sv */
`timescale 1ns/100ps

/*
 * UART receiver
 * Synchronizes the line, samples each bit at mid period and checks the
 * stop bit; delivers the word with a one-cycle valid strobe
 */
module uart_rx
    import uart_pkg::*;
#(
    parameter int NB_DATA = 8
) (
    input  logic               clk,
    input  logic               i_rst,
    input  logic               i_tick,
    input  logic               i_rx,
    output logic               o_rx_valid,
    output logic [NB_DATA-1:0] o_rx_data,
    output logic               o_frame_err
);

    localparam int NB_BITCNT = (NB_DATA > 1) ? $clog2(NB_DATA) : 1;

    localparam tick_cnt_t            LAST_TICK = tick_cnt_t'(OVERSAMPLE - 1);
    localparam logic [NB_BITCNT-1:0] LAST_BIT  = NB_BITCNT'(NB_DATA - 1);

    logic rx_meta_q;
    logic rx_sync_q;
    logic rx_prev_q;   // For falling edge detect
    logic rx_fall;

    rx_state_t            state_q, state_d;
    tick_cnt_t            tick_q, tick_d;
    logic [NB_BITCNT-1:0] bit_q, bit_d;
    logic [NB_DATA-1:0]   shift_q, shift_d;
    logic                 bit_end;

    // Two-flop synchronizer, idles high like the line
    always_ff @(posedge clk) begin
        if (i_rst) begin
            rx_meta_q <= 1'b1;
            rx_sync_q <= 1'b1;
            rx_prev_q <= 1'b1;
        end else begin
            rx_meta_q <= i_rx;
            rx_sync_q <= rx_meta_q;
            rx_prev_q <= rx_sync_q;
        end
    end

    assign rx_fall = rx_prev_q && !rx_sync_q;
    assign bit_end = i_tick && (tick_q == LAST_TICK);

    always_ff @(posedge clk) begin
        if (i_rst) begin
            state_q <= RX_IDLE;
            tick_q  <= '0;
            bit_q   <= '0;
        end else begin
            state_q <= state_d;
            tick_q  <= tick_d;
            bit_q   <= bit_d;
        end
    end

    always_ff @(posedge clk) begin
        shift_q <= shift_d;
    end

    always_comb begin
        state_d = state_q;
        tick_d  = tick_q;
        bit_d   = bit_q;
        shift_d = shift_q;

        case (state_q)
            RX_IDLE: begin
                if (rx_fall) begin
                    state_d = RX_START;
                    tick_d  = '0;
                end
            end
            RX_START: begin
                if (i_tick && tick_q == MID_TICK) begin
                    if (rx_sync_q) begin
                        state_d = RX_IDLE;  // Glitch, no start bit
                    end else begin
                        state_d = RX_DATA;
                        tick_d  = '0;
                        bit_d   = '0;
                    end
                end else if (i_tick) begin
                    tick_d = tick_q + 1'b1;
                end
            end
            RX_DATA: begin
                if (bit_end) begin
                    // LSB arrives first, so fill from the top
                    tick_d  = '0;
                    shift_d = {rx_sync_q, shift_q[NB_DATA-1:1]};
                    if (bit_q == LAST_BIT)
                        state_d = RX_STOP;
                    else
                        bit_d = bit_q + 1'b1;
                end else if (i_tick) begin
                    tick_d = tick_q + 1'b1;
                end
            end
            RX_STOP: begin
                if (bit_end)
                    state_d = RX_IDLE;
                else if (i_tick)
                    tick_d = tick_q + 1'b1;
            end
            default: state_d = RX_IDLE;
        endcase
    end

    assign o_rx_valid  = (state_q == RX_STOP) && bit_end;  // Stop-bit sample
    assign o_frame_err = o_rx_valid && !rx_sync_q;
    assign o_rx_data   = shift_q;

    a_err_with_valid: assert property (@(posedge clk) disable iff (i_rst)
        o_frame_err |-> o_rx_valid);

endmodule

/* uart_top.sv */
`timescale 1ns/100ps

/*
 * UART subsystem
 * Configuration registers, shared baud tick, transmitter and receiver
 */
module uart_top
    import uart_pkg::*;
#(
    parameter int       NB_DATA       = 8,
    parameter divisor_t RESET_DIVISOR = 16'd26
) (
    input  logic               clk,
    input  logic               i_rst,
    input  logic               i_cfg_we,
    input  divisor_t           i_cfg_divisor,
    input  logic               i_tx_start,
    input  logic [NB_DATA-1:0] i_tx_data,
    input  logic               i_rx,
    output logic               o_tx,
    output logic               o_tx_done,
    output logic               o_rx_valid,
    output logic [NB_DATA-1:0] o_rx_data,
    output logic               o_frame_err_sticky
);

    divisor_t divisor;
    logic     tick;       // Shared by both directions
    logic     frame_err;

    uart_cfg_regs #(
        .RESET_DIVISOR (RESET_DIVISOR)
    ) cfg_regs_i (
        .clk                (clk),
        .i_rst              (i_rst),
        .i_cfg_we           (i_cfg_we),
        .i_cfg_divisor      (i_cfg_divisor),
        .i_frame_err        (frame_err),
        .o_divisor          (divisor),
        .o_frame_err_sticky (o_frame_err_sticky)
    );

    uart_baud_gen baud_gen_i (
        .clk       (clk),
        .i_rst     (i_rst),
        .i_divisor (divisor),
        .o_tick    (tick)
    );

    uart_tx #(
        .NB_DATA (NB_DATA)
    ) tx_i (
        .clk        (clk),
        .i_rst      (i_rst),
        .i_tick     (tick),
        .i_tx_start (i_tx_start),
        .i_tx_data  (i_tx_data),
        .o_tx       (o_tx),
        .o_tx_done  (o_tx_done)
    );

    uart_rx #(
        .NB_DATA (NB_DATA)
    ) rx_i (
        .clk         (clk),
        .i_rst       (i_rst),
        .i_tick      (tick),
        .i_rx        (i_rx),
        .o_rx_valid  (o_rx_valid),
        .o_rx_data   (o_rx_data),
        .o_frame_err (frame_err)
    );

endmodule

/* uart_tx.sv */
`timescale 1ns/100ps

/*
 * UART transmitter
 * Sends a start bit, NB_DATA data bits LSB first and a stop bit,
 * each bit held for OVERSAMPLE ticks; o_tx_done marks the end of the stop bit
 */
module uart_tx
    import uart_pkg::*;
#(
    parameter int NB_DATA = 8
) (
    input  logic               clk,
    input  logic               i_rst,
    input  logic               i_tick,
    input  logic               i_tx_start,
    input  logic [NB_DATA-1:0] i_tx_data,
    output logic               o_tx,
    output logic               o_tx_done
);

    localparam int NB_BITCNT = (NB_DATA > 1) ? $clog2(NB_DATA) : 1;

    localparam tick_cnt_t            LAST_TICK = tick_cnt_t'(OVERSAMPLE - 1);
    localparam logic [NB_BITCNT-1:0] LAST_BIT  = NB_BITCNT'(NB_DATA - 1);

    tx_state_t            state_q, state_d;
    tick_cnt_t            tick_q, tick_d;
    logic [NB_BITCNT-1:0] bit_q, bit_d;
    logic [NB_DATA-1:0]   shift_q, shift_d;
    logic                 tx_q, tx_d;
    logic                 bit_end;

    assign bit_end = i_tick && (tick_q == LAST_TICK);  // 16th tick of a bit
    assign o_tx    = tx_q;

    always_ff @(posedge clk) begin
        if (i_rst) begin
            state_q <= TX_IDLE;
            tick_q  <= '0;
            bit_q   <= '0;
            tx_q    <= 1'b1;
        end else begin
            state_q <= state_d;
            tick_q  <= tick_d;
            bit_q   <= bit_d;
            tx_q    <= tx_d;
        end
    end

    always_ff @(posedge clk) begin
        shift_q <= shift_d;
    end

    always_comb begin
        state_d   = state_q;
        tick_d    = tick_q;
        bit_d     = bit_q;
        shift_d   = shift_q;
        o_tx_done = 1'b0;

        case (state_q)
            TX_IDLE: begin
                if (i_tx_start) begin  // Start while busy never reaches here
                    state_d = TX_START;
                    tick_d  = '0;
                    shift_d = i_tx_data;
                end
            end
            TX_START: begin
                if (bit_end) begin
                    state_d = TX_DATA;
                    tick_d  = '0;
                    bit_d   = '0;
                end else if (i_tick) begin
                    tick_d = tick_q + 1'b1;
                end
            end
            TX_DATA: begin
                if (bit_end) begin
                    tick_d  = '0;
                    shift_d = shift_q >> 1;
                    if (bit_q == LAST_BIT)
                        state_d = TX_STOP;
                    else
                        bit_d = bit_q + 1'b1;
                end else if (i_tick) begin
                    tick_d = tick_q + 1'b1;
                end
            end
            TX_STOP: begin
                if (bit_end) begin
                    state_d   = TX_IDLE;
                    o_tx_done = 1'b1;
                end else if (i_tick) begin
                    tick_d = tick_q + 1'b1;
                end
            end
            default: state_d = TX_IDLE;
        endcase

        // Line level follows the state being entered
        case (state_d)
            TX_START: tx_d = 1'b0;
            TX_DATA:  tx_d = shift_d[0];
            default:  tx_d = 1'b1;
        endcase
    end

    a_idle_high: assert property (@(posedge clk) disable iff (i_rst)
        (state_q == TX_IDLE) |-> o_tx);

endmodule
